/* verilog/ecc_mem_pkg.sv */
// ECC scratchpad shared types

package ecc_mem_pkg;

  // Data bits held in one memory word
  localparam int unsigned DATA_W = 32;

  // Six Hamming check bits plus one overall parity bit
  localparam int unsigned PARITY_W = 7;

  // Stored codeword, data and parity together
  localparam int unsigned CODE_W = DATA_W + PARITY_W;

  // Host word address, bank select in the low bits and row above them
  localparam int unsigned ADDR_W = 8;

  // Outcome of a decode, also carried in every response
  typedef enum logic [1:0] {
    ERR_NONE          = 2'd0,
    ERR_CORRECTED     = 2'd1,
    ERR_UNCORRECTABLE = 2'd2
  } ecc_err_e;

  // Host request
  // The flip mask is XORed into the codeword on its way into the array
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [CODE_W-1:0] flip;
  } mem_req_t;

  // Response to the host
  // Stores answer with zero data, zero syndrome and ERR_NONE
  typedef struct packed {
    logic                write;
    logic [DATA_W-1:0]   rdata;
    logic [PARITY_W-1:0] syndrome;
    ecc_err_e            err;
  } mem_rsp_t;

endpackage : ecc_mem_pkg

/* verilog/ecc_wrap.sv */
// Hamming SEC-DED codec

`timescale 1ns/1ps

module ecc_wrap #(
  parameter  int unsigned DataWidth = 32,
  // Hamming check bits needed to cover the data and themselves
  localparam int unsigned HamWidth  = $clog2(DataWidth + $clog2(DataWidth) + 1),
  localparam int unsigned HamLen    = DataWidth + HamWidth,
  localparam int unsigned CodeWidth = HamLen + 1
) (
  input  logic [DataWidth-1:0] wdata_i,
  output logic [CodeWidth-1:0] wdata_o,
  input  logic [CodeWidth-1:0] rdata_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic [HamWidth:0]    syndrome_o,
  output ecc_mem_pkg::ecc_err_e error_o
);

  logic [HamLen-1:0]   enc_ham;
  logic [HamLen-1:0]   dec_ham;
  logic [HamWidth-1:0] syndrome;
  logic                parity_odd;

  // Encoder
  // Codeword position pos (1-based) sits at bit pos-1, check bits at powers of two
  always_comb begin
    int unsigned j;
    enc_ham = '0;
    j = 0;
    // Data bits fill every position that is not a power of two
    for (int unsigned pos = 1; pos <= HamLen; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        enc_ham[pos-1] = wdata_i[j];
        j++;
      end
    end
    // Check bit p covers every position with bit p set in its index
    for (int unsigned p = 0; p < HamWidth; p++) begin
      for (int unsigned pos = 1; pos <= HamLen; pos++) begin
        if ((pos & (1 << p)) != 0) begin
          enc_ham[(1<<p)-1] = enc_ham[(1<<p)-1] ^ enc_ham[pos-1];
        end
      end
    end
    // Overall parity makes the whole word even and goes on top
    wdata_o = {^enc_ham, enc_ham};
  end

  // Decoder
  always_comb begin
    int unsigned j;
    syndrome = '0;
    for (int unsigned p = 0; p < HamWidth; p++) begin
      for (int unsigned pos = 1; pos <= HamLen; pos++) begin
        if ((pos & (1 << p)) != 0) begin
          syndrome[p] = syndrome[p] ^ rdata_i[pos-1];
        end
      end
    end
    // An odd word means an odd number of flipped bits, most likely one
    parity_odd = ^rdata_i;

    dec_ham = rdata_i[HamLen-1:0];
    if (parity_odd && (syndrome != '0) && (syndrome <= HamLen)) begin
      dec_ham[syndrome-1] = ~dec_ham[syndrome-1];
    end

    // Zero syndrome with odd parity is the top parity bit alone, data untouched
    if (!parity_odd && (syndrome == '0)) begin
      error_o = ecc_mem_pkg::ERR_NONE;
    end else if (parity_odd && (syndrome <= HamLen)) begin
      error_o = ecc_mem_pkg::ERR_CORRECTED;
    end else begin
      // Even parity with a nonzero syndrome, or a syndrome past the word end
      error_o = ecc_mem_pkg::ERR_UNCORRECTABLE;
    end

    rdata_o = '0;
    j = 0;
    for (int unsigned pos = 1; pos <= HamLen; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        rdata_o[j] = dec_ham[pos-1];
        j++;
      end
    end
  end

  // The overall parity check sits above the Hamming syndrome
  assign syndrome_o = {parity_odd, syndrome};

endmodule : ecc_wrap

/* verilog/ecc_bank.sv */
// ECC protected SRAM bank

`timescale 1ns/1ps

module ecc_bank #(
  parameter int unsigned BankDepth = 64,
  localparam int unsigned RowW     = $clog2(BankDepth)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  ecc_mem_pkg::mem_req_t req_i,
  input  logic [RowW-1:0]       row_i,
  output logic                  rsp_valid_o,
  output ecc_mem_pkg::mem_rsp_t rsp_o
);

  logic [ecc_mem_pkg::CODE_W-1:0]   mem_q [BankDepth];
  logic [ecc_mem_pkg::CODE_W-1:0]   enc_code;
  logic [ecc_mem_pkg::CODE_W-1:0]   rd_code_q;
  logic [ecc_mem_pkg::DATA_W-1:0]   dec_data;
  logic [ecc_mem_pkg::PARITY_W-1:0] dec_syndrome;
  ecc_mem_pkg::ecc_err_e            dec_err;
  logic                             rd_valid_q;
  logic                             rd_write_q;

  // Encode on the way in, decode the raw word held after the array read
  ecc_wrap #(
    .DataWidth  (ecc_mem_pkg::DATA_W)
  ) u_ecc (
    .wdata_i    (req_i.wdata),
    .wdata_o    (enc_code),
    .rdata_i    (rd_code_q),
    .rdata_o    (dec_data),
    .syndrome_o (dec_syndrome),
    .error_o    (dec_err)
  );

  // Array access happens on the edge that accepts the request
  // The flip mask injects faults into the stored word only
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.write) begin
      mem_q[row_i] <= enc_code ^ req_i.flip;
    end
    if (req_valid_i && !req_i.write) begin
      rd_code_q <= mem_q[row_i];
    end
  end

  // Stage 1 tracks which kind of access is in flight
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
      rd_write_q <= 1'b0;
    end else begin
      rd_valid_q <= req_valid_i;
      rd_write_q <= req_valid_i & req_i.write;
    end
  end

  // Stage 2 registers the response one cycle after the access
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= rd_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_q) begin
      rsp_o.write <= rd_write_q;
      if (rd_write_q) begin
        // A store only acknowledges
        rsp_o.rdata    <= '0;
        rsp_o.syndrome <= '0;
        rsp_o.err      <= ecc_mem_pkg::ERR_NONE;
      end else begin
        rsp_o.rdata    <= dec_data;
        rsp_o.syndrome <= dec_syndrome;
        rsp_o.err      <= dec_err;
      end
    end
  end

endmodule : ecc_bank

/* verilog/bank_dispatch.sv */
// Request credit tracking and bank select

`timescale 1ns/1ps

module bank_dispatch #(
  parameter  int unsigned NumBanks   = 4,
  parameter  int unsigned BankDepth  = 64,
  parameter  int unsigned NumCredits = 4,
  localparam int unsigned BankSelW   = $clog2(NumBanks),
  localparam int unsigned RowW       = $clog2(BankDepth),
  localparam int unsigned CreditW    = $clog2(NumCredits + 1)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 req_valid_i,
  input  ecc_mem_pkg::mem_req_t                req_i,
  input  logic                                 credit_ret_i,
  output logic [NumBanks-1:0]                  bank_req_valid_o,
  output ecc_mem_pkg::mem_req_t [NumBanks-1:0] bank_req_o,
  output logic [NumBanks-1:0][RowW-1:0]        bank_row_o
);

  logic [CreditW-1:0]  credit_q;
  logic [BankSelW-1:0] bank_sel;
  logic [RowW-1:0]     row;
  logic                accept;

  // Mirror of the credits the host holds, full after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CreditW'(NumCredits);
    end else begin
      credit_q <= credit_q - CreditW'(accept) + CreditW'(credit_ret_i);
    end
  end

  // A request without a credit is a host protocol error and is dropped
  assign accept = req_valid_i && (credit_q != '0);

  // Low address bits pick the bank, the bits above them the row
  assign bank_sel = req_i.addr[BankSelW-1:0];
  assign row      = req_i.addr[BankSelW +: RowW];

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_req_valid_o[b] = accept && (bank_sel == BankSelW'(b));
      // Every bank sees the request, only the selected one acts on it
      bank_req_o[b]       = req_i;
      bank_row_o[b]       = row;
    end
  end

  // The host must hold a credit for every request it sends
  a_req_has_credit : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (credit_q != '0)
  ) else $error("bank_dispatch: request sent with no credit held");

  // An accepted request reaches exactly one bank
  a_bank_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept |-> $onehot(bank_req_valid_o)
  ) else $error("bank_dispatch: bank valid is not one-hot");

endmodule : bank_dispatch

/* verilog/rsp_collect.sv */
// Response FIFO with credit release

`timescale 1ns/1ps

module rsp_collect #(
  parameter  int unsigned NumBanks   = 4,
  parameter  int unsigned NumCredits = 4,
  localparam int unsigned PtrW       = (NumCredits > 1) ? $clog2(NumCredits) : 1,
  localparam int unsigned CountW     = $clog2(NumCredits + 1),
  localparam int unsigned RspCredW   = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [NumBanks-1:0]                  bank_rsp_valid_i,
  input  ecc_mem_pkg::mem_rsp_t [NumBanks-1:0] bank_rsp_i,
  input  logic                                 rsp_credit_i,
  output logic                                 rsp_valid_o,
  output ecc_mem_pkg::mem_rsp_t                rsp_o,
  output logic                                 req_credit_o
);

  ecc_mem_pkg::mem_rsp_t fifo_q [NumCredits];
  ecc_mem_pkg::mem_rsp_t push_rsp;
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CountW-1:0]     count_q;
  logic [RspCredW-1:0]   rsp_cred_q;
  logic                  push;
  logic                  pop;

  // Banks share one latency, so at most one of them answers per cycle
  assign push = |bank_rsp_valid_i;

  always_comb begin
    push_rsp = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (bank_rsp_valid_i[b]) begin
        push_rsp = bank_rsp_i[b];
      end
    end
  end

  // Release needs both a stored response and a response credit
  assign pop = (count_q != '0) && (rsp_cred_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_rsp;
    end
    if (pop) begin
      rsp_o <= fifo_q[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      rsp_cred_q   <= '0;
      rsp_valid_o  <= 1'b0;
      req_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(NumCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(NumCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q    <= count_q + CountW'(push) - CountW'(pop);
      rsp_cred_q <= rsp_cred_q + RspCredW'(rsp_credit_i) - RspCredW'(pop);
      // The freed entry hands its request credit back in the same cycle
      rsp_valid_o  <= pop;
      req_credit_o <= pop;
    end
  end

  // Request credits bound the entries, so a full FIFO never sees a push
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push |-> (count_q < CountW'(NumCredits))
  ) else $error("rsp_collect: push into a full FIFO");

  a_one_bank_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_rsp_valid_i)
  ) else $error("rsp_collect: more than one bank response in a cycle");

endmodule : rsp_collect

/* verilog/ecc_mem_top.sv */
// ECC scratchpad memory top

`timescale 1ns/1ps

module ecc_mem_top #(
  parameter  int unsigned NumBanks   = 4,
  parameter  int unsigned BankDepth  = 64,
  parameter  int unsigned NumCredits = 4,
  localparam int unsigned RowW       = $clog2(BankDepth)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  ecc_mem_pkg::mem_req_t req_i,
  output logic                  req_credit_o,
  input  logic                  rsp_credit_i,
  output logic                  rsp_valid_o,
  output ecc_mem_pkg::mem_rsp_t rsp_o
);

  logic [NumBanks-1:0]                  bank_req_valid;
  ecc_mem_pkg::mem_req_t [NumBanks-1:0] bank_req;
  logic [NumBanks-1:0][RowW-1:0]        bank_row;
  logic [NumBanks-1:0]                  bank_rsp_valid;
  ecc_mem_pkg::mem_rsp_t [NumBanks-1:0] bank_rsp;

  // Credits returned to the host also refill the dispatcher count
  bank_dispatch #(
    .NumBanks         (NumBanks),
    .BankDepth        (BankDepth),
    .NumCredits       (NumCredits)
  ) u_dispatch (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .credit_ret_i     (req_credit_o),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req),
    .bank_row_o       (bank_row)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    ecc_bank #(
      .BankDepth   (BankDepth)
    ) u_bank (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (bank_req_valid[b]),
      .req_i       (bank_req[b]),
      .row_i       (bank_row[b]),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_o       (bank_rsp[b])
    );
  end

  rsp_collect #(
    .NumBanks         (NumBanks),
    .NumCredits       (NumCredits)
  ) u_collect (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_i       (bank_rsp),
    .rsp_credit_i     (rsp_credit_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o),
    .req_credit_o     (req_credit_o)
  );

endmodule : ecc_mem_top

/* sim/ecc_mem_tb.sv */
// ECC scratchpad testbench

`timescale 1ns/1ps

module ecc_mem_tb;

  localparam int unsigned num_banks   = 4;
  localparam int unsigned bank_depth  = 64;
  localparam int unsigned num_credits = 4;
  localparam int unsigned addr_w      = ecc_mem_pkg::ADDR_W;
  localparam int unsigned data_w      = ecc_mem_pkg::DATA_W;
  localparam int unsigned exp_depth   = 256;
  localparam int unsigned timeout_cyc = 2000;

  // What the host expects back for one request, in request order
  typedef struct packed {
    logic                  write;
    logic [data_w-1:0]     rdata;
    ecc_mem_pkg::ecc_err_e err;
  } exp_rsp_t;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  req_valid_i;
  ecc_mem_pkg::mem_req_t req_i;
  logic                  req_credit_o;
  logic                  rsp_credit_i;
  logic                  rsp_valid_o;
  ecc_mem_pkg::mem_rsp_t rsp_o;

  // Reference memory holds the clean data and how many bits were flipped on store
  logic [data_w-1:0] ref_data [2**addr_w];
  int                ref_flips [2**addr_w];
  bit                ref_written [2**addr_w];
  exp_rsp_t          exp_buf [exp_depth];
  int                exp_wr = 0;
  int                exp_rd = 0;
  int                req_credits = num_credits;
  int                rsp_cred_out = 0;
  int                reqs_sent = 0;
  int                grants_given = 0;
  int                rsp_seen = 0;
  int                err_cnt = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                seed = 32'h435a;

  ecc_mem_top #(
    .NumBanks     (num_banks),
    .BankDepth    (bank_depth),
    .NumCredits   (num_credits)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .rsp_credit_i (rsp_credit_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Returned credits and released responses are both seen on the rising edge
  always @(posedge clk_i) begin
    if (rst_n_i && req_credit_o) begin
      req_credits = req_credits + 1;
    end
    if (rst_n_i && rsp_valid_o) begin
      exp_rd       = exp_rd + 1;
      rsp_cred_out = rsp_cred_out - 1;
      rsp_seen     = rsp_seen + 1;
    end
  end

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // Zero syndrome only for a clean word, and data is meaningless after a double error
  function automatic bit rsp_ok(input ecc_mem_pkg::mem_rsp_t r, input exp_rsp_t e);
    bit ok;
    ok = (r.write === e.write) && (r.err === e.err);
    if (e.err != ecc_mem_pkg::ERR_UNCORRECTABLE) begin
      ok = ok && (r.rdata === e.rdata);
    end
    if (e.err == ecc_mem_pkg::ERR_NONE) begin
      ok = ok && (r.syndrome === '0);
    end else begin
      ok = ok && !$isunknown(r.syndrome) && (r.syndrome != '0);
    end
    return ok;
  endfunction

  a_rsp_match : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> rsp_ok(rsp_o, exp_buf[exp_rd % exp_depth]))
  else begin
    $display("ERROR at %0t: response %h differs from expected %h", $time,
             $sampled(rsp_o), $sampled(exp_buf[exp_rd % exp_depth]));
    err_cnt++;
  end

  a_rsp_expected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> (exp_rd != exp_wr))
  else begin
    $display("ERROR at %0t: response with no request outstanding", $time);
    err_cnt++;
  end

  a_rsp_has_credit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> (rsp_cred_out > 0))
  else begin
    $display("ERROR at %0t: response with no response credit granted", $time);
    err_cnt++;
  end

  // Every released response frees exactly one request credit
  a_credit_with_rsp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_credit_o == rsp_valid_o)
  else begin
    $display("ERROR at %0t: req_credit_o %0b with rsp_valid_o %0b", $time,
             $sampled(req_credit_o), $sampled(rsp_valid_o));
    err_cnt++;
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_credits + int'(req_credit_o)) <= num_credits)
  else begin
    $display("ERROR at %0t: host would hold more than %0d credits", $time, num_credits);
    err_cnt++;
  end

  task automatic next_cycle();
    @(negedge clk_i);
    req_valid_i  = 1'b0;
    rsp_credit_i = 1'b0;
  endtask

  task automatic grant();
    rsp_credit_i = 1'b1;
    rsp_cred_out = rsp_cred_out + 1;
    grants_given = grants_given + 1;
  endtask

  // Drives one request in the current cycle and records what should come back
  task automatic issue(input logic wr, input logic [addr_w-1:0] addr,
                       input logic [data_w-1:0] data, input int nflips);
    ecc_mem_pkg::mem_req_t req;
    exp_rsp_t              exp_rsp;
    int unsigned           b0;
    int unsigned           b1;
    req       = '0;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wr ? data : '0;
    b0        = rand_below(ecc_mem_pkg::CODE_W);
    b1        = b0;
    if (nflips > 0) begin
      req.flip[b0] = 1'b1;
    end
    // The second flipped bit must differ from the first
    if (nflips > 1) begin
      while (b1 == b0) begin
        b1 = rand_below(ecc_mem_pkg::CODE_W);
      end
      req.flip[b1] = 1'b1;
    end
    exp_rsp.write = wr;
    exp_rsp.rdata = '0;
    exp_rsp.err   = ecc_mem_pkg::ERR_NONE;
    if (wr) begin
      ref_data[addr]    = data;
      ref_flips[addr]   = nflips;
      ref_written[addr] = 1'b1;
    end else begin
      exp_rsp.rdata = ref_data[addr];
      if (ref_flips[addr] == 1) begin
        exp_rsp.err = ecc_mem_pkg::ERR_CORRECTED;
      end else if (ref_flips[addr] > 1) begin
        exp_rsp.err = ecc_mem_pkg::ERR_UNCORRECTABLE;
      end
    end
    exp_buf[exp_wr % exp_depth] = exp_rsp;
    exp_wr      = exp_wr + 1;
    req_valid_i = 1'b1;
    req_i       = req;
    req_credits = req_credits - 1;
    reqs_sent   = reqs_sent + 1;
  endtask

  // Waits for a request credit, then sends and finishes the cycle
  task automatic send(input logic wr, input logic [addr_w-1:0] addr,
                      input logic [data_w-1:0] data, input int nflips);
    int n;
    n = 0;
    while (req_credits == 0 && n < timeout_cyc) begin
      next_cycle();
      n++;
    end
    if (req_credits == 0) begin
      $display("Timed out at %0t waiting for a request credit", $time);
      err_cnt++;
    end else begin
      issue(wr, addr, data, nflips);
      next_cycle();
    end
  endtask

  // Grants the missing response credits until every response is back
  task automatic drain();
    int n;
    n = 0;
    while (exp_rd != exp_wr && n < timeout_cyc) begin
      if (grants_given < reqs_sent) begin
        grant();
      end
      next_cycle();
      n++;
    end
    if (exp_rd != exp_wr) begin
      $display("Timed out at %0t with %0d responses missing", $time, exp_wr - exp_rd);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("Test %0d %s: passed", num, name);
    end else begin
      fail_cnt++;
      $display("Test %0d %s: failed", num, name);
    end
  endtask

  initial begin
    int          err_before;
    int          ops;
    int          cyc;
    int          n;
    int          seen0;
    logic [addr_w-1:0] addr;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_credit_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle cycles only, the assertions flag any spurious response or credit
    err_before = err_cnt;
    repeat (10) next_cycle();
    report_test(1, "idle after reset", err_before);

    err_before = err_cnt;
    send(1'b1, 8'h05, 32'hdead_beef, 0);
    send(1'b0, 8'h05, '0, 0);
    drain();
    report_test(2, "clean write and read", err_before);

    err_before = err_cnt;
    send(1'b1, 8'h16, 32'h1234_5678, 1);
    send(1'b0, 8'h16, '0, 0);
    drain();
    report_test(3, "single bit corrected", err_before);

    err_before = err_cnt;
    send(1'b1, 8'h27, 32'hcafe_f00d, 2);
    send(1'b0, 8'h27, '0, 0);
    drain();
    report_test(4, "double bit detected", err_before);

    // All four loads wait in the FIFO until credits arrive one by one
    err_before = err_cnt;
    send(1'b0, 8'h05, '0, 0);
    send(1'b0, 8'h16, '0, 0);
    send(1'b0, 8'h27, '0, 0);
    send(1'b0, 8'h05, '0, 0);
    repeat (10) next_cycle();
    for (int k = 0; k < num_credits; k++) begin
      seen0 = rsp_seen;
      grant();
      n = 0;
      next_cycle();
      while (rsp_seen == seen0 && n < timeout_cyc) begin
        next_cycle();
        n++;
      end
      if (rsp_seen == seen0) begin
        $display("Timed out at %0t waiting for response %0d", $time, k);
        err_cnt++;
      end
    end
    drain();
    report_test(5, "back-pressure", err_before);

    err_before = err_cnt;
    ops = 0;
    cyc = 0;
    while (ops < 60 && cyc < timeout_cyc) begin
      if (grants_given < reqs_sent && rand_below(2) == 1) begin
        grant();
      end
      if (req_credits > 0 && rand_below(4) != 0) begin
        addr = rand_below(2**addr_w);
        // A load from an unwritten word has no defined value, so it becomes a store
        if (ref_written[addr] && rand_below(2) == 0) begin
          issue(1'b0, addr, '0, 0);
        end else begin
          issue(1'b1, addr, $random(seed), rand_below(3));
        end
        ops++;
      end
      next_cycle();
      cyc++;
    end
    if (ops < 60) begin
      $display("Timed out at %0t after %0d of 60 random requests", $time, ops);
      err_cnt++;
    end
    drain();
    report_test(6, "random traffic", err_before);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : ecc_mem_tb

/* verilog.f */
verilog/ecc_mem_pkg.sv
verilog/ecc_wrap.sv
verilog/ecc_bank.sv
verilog/bank_dispatch.sv
verilog/rsp_collect.sv
verilog/ecc_mem_top.sv
sim/ecc_mem_tb.sv
